// ==== common/mdio_pkg.sv ====
`default_nettype none

package mdio_pkg;

	//////////////////////////////////////////////////////////////////////
	// Field widths
	//////////////////////////////////////////////////////////////////////

	// PHY address on the management bus
	typedef logic [4:0] phy_addr_t;

	// Register number inside one PHY
	typedef logic [4:0] reg_addr_t;

	// One management register
	typedef logic [15:0] mdio_data_t;

	//////////////////////////////////////////////////////////////////////
	// Frame field codes
	//////////////////////////////////////////////////////////////////////

	localparam logic [1:0] MDIO_START = 2'b01;
	localparam logic [1:0] OP_READ    = 2'b10;
	localparam logic [1:0] OP_WRITE   = 2'b01;

	// Master drives 10 on a write, a read leaves the line to the PHY
	localparam logic [1:0] TA_WRITE = 2'b10;

	// Start, opcode, PHY, register, turnaround
	localparam int HEADER_BITS = 16;

	// Ones sent once after reset
	localparam int PREAMBLE_BITS = 64;

	//////////////////////////////////////////////////////////////////////
	// Frame engine states
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		FS_PREAMBLE,
		FS_IDLE,
		FS_ADDRESS,
		FS_READ,
		FS_WRITE
	} frame_state_t;

endpackage

`default_nettype wire

// ==== mdio/mdc_clock_gen.sv ====
`default_nettype none

module mdc_clock_gen #(
	parameter int CLKBITS = 2
) (
	input  logic	i_clk,
	input  logic	i_reset,
	output logic	o_mdc,
	output logic	o_bit_stb
);

	logic [CLKBITS-1:0] div_cnt;

	// Free running divider, MDC is its top bit
	always_ff @(posedge i_clk)
		if (i_reset)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;

	assign o_mdc = div_cnt[CLKBITS-1];

	// Count is all ones minus one here, so the strobe lands on the
	// last clock of the period and the registers it enables change
	// on the same edge that drops MDC
	always_ff @(posedge i_clk)
		if (i_reset)
			o_bit_stb <= 1'b0;
		else
			o_bit_stb <= (&div_cnt[CLKBITS-1:1]) && !div_cnt[0];

endmodule

`default_nettype wire

// ==== mdio/mdio_frame_engine.sv ====
`default_nettype none

module mdio_frame_engine #(
	parameter mdio_pkg::phy_addr_t PHY_ADDR = 5'd1
) (
	input  logic			i_clk,
	input  logic			i_reset,
	input  logic			i_bit_stb,
	input  logic			i_rd_pend,
	input  logic			i_wr_pend,
	input  mdio_pkg::reg_addr_t	i_reg_addr,
	input  mdio_pkg::mdio_data_t	i_wr_data,
	input  logic			i_mdio,
	output logic			o_mdio,
	output logic			o_mdwe,
	output logic			o_idle,
	output logic			o_data_phase,
	output logic			o_done,
	output mdio_pkg::mdio_data_t	o_rd_data
);
	import mdio_pkg::*;

	localparam int DATA_BITS = $bits(mdio_data_t);

	frame_state_t	state;
	logic [5:0]	bit_pos;
	mdio_data_t	tx_sreg;
	mdio_data_t	rx_sreg;
	mdio_data_t	header;
	logic		start_frame;
	logic		hdr_end;
	logic		frame_end;

	assign o_idle       = (state == FS_IDLE);
	assign o_data_phase = (state == FS_READ) || (state == FS_WRITE);

	// Event decodes, all on a bit boundary
	assign start_frame = i_bit_stb && o_idle && (i_rd_pend || i_wr_pend);
	assign hdr_end     = i_bit_stb && (state == FS_ADDRESS) && (bit_pos == '0);
	assign frame_end   = i_bit_stb && o_data_phase && (bit_pos == '0);

	// Read turnaround stays 11 in the shifter, the line is released then
	assign header = {MDIO_START, i_wr_pend ? OP_WRITE : OP_READ, PHY_ADDR,
		i_reg_addr, i_wr_pend ? TA_WRITE : 2'b11};

	//////////////////////////////////////////////////////////////////////
	// State and bit position
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			state   <= FS_PREAMBLE;
			bit_pos <= 6'(PREAMBLE_BITS - 1);
			o_mdwe  <= 1'b1;
			o_done  <= 1'b0;
		end else
		begin
			o_done <= frame_end;
			if (i_bit_stb)
			begin
				if (bit_pos != '0)
					bit_pos <= bit_pos - 1'b1;
				case (state)
				FS_PREAMBLE:
					if (bit_pos == '0)
						state <= FS_IDLE;
				FS_IDLE:
					if (i_rd_pend || i_wr_pend)
					begin
						state   <= FS_ADDRESS;
						bit_pos <= 6'(HEADER_BITS - 1);
					end
				FS_ADDRESS:
				begin
					// Let go of the line for a read turnaround
					o_mdwe <= i_wr_pend || (bit_pos > 6'd2);
					if (bit_pos == '0)
					begin
						state   <= i_wr_pend ? FS_WRITE : FS_READ;
						bit_pos <= 6'(DATA_BITS - 1);
					end
				end
				FS_READ, FS_WRITE:
					if (bit_pos == '0)
					begin
						state  <= FS_IDLE;
						o_mdwe <= 1'b1;
					end
				default:
				begin
					state   <= FS_PREAMBLE;
					bit_pos <= 6'(PREAMBLE_BITS - 1);
					o_mdwe  <= 1'b1;
				end
				endcase
			end
		end

	//////////////////////////////////////////////////////////////////////
	// Transmit shifter, ones fill in behind the frame
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
		if (i_reset)
			tx_sreg <= '1;
		else if (start_frame)
			tx_sreg <= header;
		else if (hdr_end && i_wr_pend)
			tx_sreg <= i_wr_data;
		else if (i_bit_stb)
			tx_sreg <= {tx_sreg[DATA_BITS-2:0], 1'b1};

	assign o_mdio = tx_sreg[DATA_BITS-1];

	//////////////////////////////////////////////////////////////////////
	// Receive shifter
	//////////////////////////////////////////////////////////////////////

	// PHY changes the line at the falling edge, so it is settled here
	always_ff @(posedge i_clk)
		if (i_bit_stb && (state == FS_READ))
			rx_sreg <= {rx_sreg[DATA_BITS-2:0], i_mdio};

	always_ff @(posedge i_clk)
		if (frame_end && (state == FS_READ))
			o_rd_data <= {rx_sreg[DATA_BITS-2:0], i_mdio};

endmodule

`default_nettype wire

// ==== hw/wb_mdio_slave.sv ====
`default_nettype none

module wb_mdio_slave (
	input  logic			i_clk,
	input  logic			i_reset,
	input  logic			i_wb_cyc,
	input  logic			i_wb_stb,
	input  logic			i_wb_we,
	input  mdio_pkg::reg_addr_t	i_wb_addr,
	input  mdio_pkg::mdio_data_t	i_wb_data,
	output logic			o_wb_stall,
	output logic			o_wb_ack,
	input  logic			i_idle,
	input  logic			i_data_phase,
	input  logic			i_done,
	output logic			o_rd_pend,
	output logic			o_wr_pend,
	output mdio_pkg::reg_addr_t	o_reg_addr,
	output mdio_pkg::mdio_data_t	o_wr_data
);

	logic accept;
	logic pre_ack;

	assign accept = i_wb_stb && !o_wb_stall;

	// Held through the frame and the ack cycle that follows it
	always_ff @(posedge i_clk)
		if (i_reset)
			o_wb_stall <= 1'b1;
		else
			o_wb_stall <= accept || !i_idle || o_rd_pend || o_wr_pend || i_done;

	// Request latches follow the bus while it is open
	always_ff @(posedge i_clk)
		if (!o_wb_stall)
		begin
			o_reg_addr <= i_wb_addr;
			o_wr_data  <= i_wb_data;
		end

	// Engine has the request once it reaches the data bits
	always_ff @(posedge i_clk)
		if (i_reset || i_data_phase)
		begin
			o_rd_pend <= 1'b0;
			o_wr_pend <= 1'b0;
		end else if (accept)
		begin
			o_rd_pend <= !i_wb_we;
			o_wr_pend <= i_wb_we;
		end

	//////////////////////////////////////////////////////////////////////
	// Acknowledge
	//////////////////////////////////////////////////////////////////////

	// Dropping cyc abandons the transfer, its frame still runs
	always_ff @(posedge i_clk)
		if (i_reset || !i_wb_cyc)
			pre_ack <= 1'b0;
		else if (accept)
			pre_ack <= 1'b1;
		else if (o_wb_ack)
			pre_ack <= 1'b0;

	always_ff @(posedge i_clk)
		if (i_reset)
			o_wb_ack <= 1'b0;
		else
			o_wb_ack <= i_done && pre_ack && i_wb_cyc;

endmodule

`default_nettype wire

// ==== hw/enet_mdio_ctrl.sv ====
`default_nettype none

module enet_mdio_ctrl #(
	parameter int			CLKBITS  = 2,
	parameter mdio_pkg::phy_addr_t	PHY_ADDR = 5'd1
) (
	input  logic			i_clk,
	input  logic			i_reset,
	input  logic			i_wb_cyc,
	input  logic			i_wb_stb,
	input  logic			i_wb_we,
	input  mdio_pkg::reg_addr_t	i_wb_addr,
	input  mdio_pkg::mdio_data_t	i_wb_data,
	output logic			o_wb_stall,
	output logic			o_wb_ack,
	output mdio_pkg::mdio_data_t	o_wb_data,
	output logic			o_mdc,
	output logic			o_mdio,
	output logic			o_mdwe,
	input  logic			i_mdio
);
	import mdio_pkg::*;

	logic		bit_stb;
	logic		idle;
	logic		data_phase;
	logic		done;
	logic		rd_pend;
	logic		wr_pend;
	reg_addr_t	reg_addr;
	mdio_data_t	wr_data;

	//////////////////////////////////////////////////////////////////////
	// MDC and bit timing
	//////////////////////////////////////////////////////////////////////

	mdc_clock_gen #(
		.CLKBITS	(CLKBITS)
	) u_clk_gen (
		.i_clk		(i_clk),
		.i_reset	(i_reset),
		.o_mdc		(o_mdc),
		.o_bit_stb	(bit_stb)
	);

	//////////////////////////////////////////////////////////////////////
	// Bus side
	//////////////////////////////////////////////////////////////////////

	wb_mdio_slave u_slave (
		.i_clk		(i_clk),
		.i_reset	(i_reset),
		.i_wb_cyc	(i_wb_cyc),
		.i_wb_stb	(i_wb_stb),
		.i_wb_we	(i_wb_we),
		.i_wb_addr	(i_wb_addr),
		.i_wb_data	(i_wb_data),
		.o_wb_stall	(o_wb_stall),
		.o_wb_ack	(o_wb_ack),
		.i_idle		(idle),
		.i_data_phase	(data_phase),
		.i_done		(done),
		.o_rd_pend	(rd_pend),
		.o_wr_pend	(wr_pend),
		.o_reg_addr	(reg_addr),
		.o_wr_data	(wr_data)
	);

	//////////////////////////////////////////////////////////////////////
	// Line side
	//////////////////////////////////////////////////////////////////////

	mdio_frame_engine #(
		.PHY_ADDR	(PHY_ADDR)
	) u_engine (
		.i_clk		(i_clk),
		.i_reset	(i_reset),
		.i_bit_stb	(bit_stb),
		.i_rd_pend	(rd_pend),
		.i_wr_pend	(wr_pend),
		.i_reg_addr	(reg_addr),
		.i_wr_data	(wr_data),
		.i_mdio		(i_mdio),
		.o_mdio		(o_mdio),
		.o_mdwe		(o_mdwe),
		.o_idle		(idle),
		.o_data_phase	(data_phase),
		.o_done		(done),
		.o_rd_data	(o_wb_data)
	);

endmodule

`default_nettype wire

// ==== verif/mdio_properties.sv ====
`default_nettype none

module mdio_properties (
	input  logic	i_clk,
	input  logic	i_reset,
	input  logic	i_wb_stb,
	input  logic	i_wb_stall,
	input  logic	i_wb_ack,
	input  logic	i_done,
	input  logic	i_mdc,
	input  logic	i_mdio,
	input  logic	i_mdwe
);
	timeunit 1ns;
	timeprecision 100ps;

	logic	inflight;
	logic	done_q;
	int	fail_count = 0;

	// From accept up to the cycle after done
	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			inflight <= 1'b0;
			done_q   <= 1'b0;
		end else
		begin
			done_q <= i_done;
			if (i_wb_stb && !i_wb_stall)
				inflight <= 1'b1;
			else if (done_q)
				inflight <= 1'b0;
		end

	stall_held: assert property (@(posedge i_clk) disable iff (i_reset)
		inflight |-> i_wb_stall)
	else
	begin
		fail_count++;
		$error("stall low while a transfer is in flight");
	end

	ack_owned: assert property (@(posedge i_clk) disable iff (i_reset)
		i_wb_ack |-> inflight)
	else
	begin
		fail_count++;
		$error("ack without an accepted transfer");
	end

	ack_single: assert property (@(posedge i_clk) disable iff (i_reset)
		i_wb_ack |=> !i_wb_ack)
	else
	begin
		fail_count++;
		$error("ack longer than one cycle");
	end

	mdio_on_fall: assert property (@(posedge i_clk) disable iff (i_reset)
		($changed(i_mdio) || $changed(i_mdwe)) |-> $fell(i_mdc))
	else
	begin
		fail_count++;
		$error("line changed away from the MDC fall");
	end

endmodule

bind enet_mdio_ctrl mdio_properties props0 (
	.i_clk		(i_clk),
	.i_reset	(i_reset),
	.i_wb_stb	(i_wb_stb),
	.i_wb_stall	(o_wb_stall),
	.i_wb_ack	(o_wb_ack),
	.i_done		(done),
	.i_mdc		(o_mdc),
	.i_mdio		(o_mdio),
	.i_mdwe		(o_mdwe)
);

`default_nettype wire

// ==== verif/mdio_checker.sv ====
`default_nettype none

module mdio_checker #(
	parameter mdio_pkg::phy_addr_t PHY_ADDR = 5'd1
) (
	input  logic			i_clk,
	input  logic			i_reset,
	input  logic			i_mdc,
	input  logic			i_mdio,
	input  logic			i_mdwe,
	input  logic			i_wb_stall,
	input  logic			i_wb_ack,
	input  mdio_pkg::mdio_data_t	i_wb_data
);
	timeunit 1ns;
	timeprecision 100ps;

	import mdio_pkg::*;

	logic [27:0]	vec_mem [0:15];
	logic		acked [0:15];
	int		nvec;
	int		error_count = 0;
	int		frame_count = 0;
	int		ack_count = 0;
	int		pre_cnt = 0;
	int		bit_cnt = 0;
	logic [31:0]	line_bits;
	logic [31:0]	we_bits;
	logic		mdc_q;

	initial
	begin
		for (int i = 0; i < 16; i++)
			vec_mem[i] = {4'hf, 24'(i)};
		$readmemh("verif/mdio_vectors.txt", vec_mem);
		nvec = 0;
		for (int i = 0; i < 16; i++)
			if (nvec == i && vec_mem[i][27:24] != 4'hf)
				nvec = i + 1;
	end

	task automatic report_error(input string msg);
		error_count++;
		$display("[ERROR] %0t: %s", $time, msg);
	endtask

	task automatic check_frame();
		logic [27:0] v;
		logic [31:0] exp_bits;
		logic [31:0] exp_we;
		logic [31:0] mask;
		if (frame_count >= nvec)
		begin
			report_error("a frame appeared on the line with no transfer left");
			frame_count++;
			return;
		end
		v = vec_mem[frame_count];
		if (v[27:24] == 4'h1)
		begin
			// Data bits belong to the PHY and are not compared here
			exp_bits = {MDIO_START, OP_READ, PHY_ADDR, v[20:16], 18'h0};
			exp_we   = {14'h3fff, 18'h0};
			mask     = {14'h3fff, 18'h0};
		end else
		begin
			exp_bits = {MDIO_START, OP_WRITE, PHY_ADDR, v[20:16], TA_WRITE, v[15:0]};
			exp_we   = '1;
			mask     = '1;
		end
		if ((line_bits & mask) != exp_bits)
			report_error($sformatf("frame %0d bits %h, expected %h",
				frame_count, line_bits & mask, exp_bits));
		if (we_bits != exp_we)
			report_error($sformatf("frame %0d mdwe %h, expected %h",
				frame_count, we_bits, exp_we));
		frame_count++;
	endtask

	task automatic sample_line_bit();
		if (pre_cnt < PREAMBLE_BITS)
		begin
			if (!i_mdwe || !i_mdio)
				report_error($sformatf("preamble bit %0d not a driven one", pre_cnt));
			if (!i_wb_stall)
				report_error("stall dropped before the preamble ended");
			pre_cnt++;
		end else if (bit_cnt == 0 && i_mdio && i_mdwe)
		begin
			// Idle ones between frames
		end else
		begin
			line_bits = {line_bits[30:0], i_mdio};
			we_bits   = {we_bits[30:0], i_mdwe};
			bit_cnt++;
			if (bit_cnt == 32)
			begin
				check_frame();
				bit_cnt = 0;
			end
		end
	endtask

	// The ack always belongs to the frame that just left the line
	task automatic check_ack();
		int idx;
		logic [27:0] v;
		ack_count++;
		idx = frame_count - 1;
		if (idx < 0)
		begin
			report_error("ack seen before any frame");
			return;
		end
		v = vec_mem[idx];
		if (v[27:24] == 4'h2)
			report_error($sformatf("ack for abandoned transfer %0d", idx));
		else if (acked[idx])
			report_error($sformatf("second ack for transfer %0d", idx));
		else
		begin
			acked[idx] = 1'b1;
			if (v[27:24] == 4'h1 && i_wb_data != v[15:0])
				report_error($sformatf("read %0d returned %h, expected %h",
					idx, i_wb_data, v[15:0]));
		end
	endtask

	always @(posedge i_clk)
	begin
		mdc_q <= i_mdc;
		if (i_reset)
		begin
			for (int i = 0; i < 16; i++)
				acked[i] = 1'b0;
		end else
		begin
			if (!mdc_q && i_mdc)
				sample_line_bit();
			if (i_wb_ack)
				check_ack();
		end
	end

	function automatic int count_missing();
		int n;
		n = 0;
		for (int i = 0; i < nvec; i++)
			if (i >= frame_count)
			begin
				$display("Transfer %0d never reached the line", i);
				n++;
			end else if (vec_mem[i][27:24] != 4'h2 && !acked[i])
			begin
				$display("Transfer %0d got no ack", i);
				n++;
			end
		return n;
	endfunction

endmodule

`default_nettype wire

// ==== verif/enet_mdio_tb.sv ====
`default_nettype none

module enet_mdio_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import mdio_pkg::*;

	localparam int		CLKBITS    = 2;
	localparam phy_addr_t	PHY_ADDR   = 5'd3;
	localparam int		MDC_CLOCKS = 1 << CLKBITS;

	logic		i_clk;
	logic		i_reset;
	logic		i_wb_cyc;
	logic		i_wb_stb;
	logic		i_wb_we;
	reg_addr_t	i_wb_addr;
	mdio_data_t	i_wb_data;
	logic		o_wb_stall;
	logic		o_wb_ack;
	mdio_data_t	o_wb_data;
	logic		o_mdc;
	logic		o_mdio;
	logic		o_mdwe;
	logic		i_mdio;

	// Op nibble, register byte, data word
	logic [27:0]	vec_mem [0:15];
	int		nvec;
	int		cycle_count = 0;
	int		cycle_limit;
	int		total_errors;
	mdio_data_t	cur_rd_data;
	logic		mdc_q;
	int		rd_bit;

	enet_mdio_ctrl #(
		.CLKBITS	(CLKBITS),
		.PHY_ADDR	(PHY_ADDR)
	) dut0 (
		.i_clk		(i_clk),
		.i_reset	(i_reset),
		.i_wb_cyc	(i_wb_cyc),
		.i_wb_stb	(i_wb_stb),
		.i_wb_we	(i_wb_we),
		.i_wb_addr	(i_wb_addr),
		.i_wb_data	(i_wb_data),
		.o_wb_stall	(o_wb_stall),
		.o_wb_ack	(o_wb_ack),
		.o_wb_data	(o_wb_data),
		.o_mdc		(o_mdc),
		.o_mdio		(o_mdio),
		.o_mdwe		(o_mdwe),
		.i_mdio		(i_mdio)
	);

	mdio_checker #(
		.PHY_ADDR	(PHY_ADDR)
	) chk0 (
		.i_clk		(i_clk),
		.i_reset	(i_reset),
		.i_mdc		(o_mdc),
		.i_mdio		(o_mdio),
		.i_mdwe		(o_mdwe),
		.i_wb_stall	(o_wb_stall),
		.i_wb_ack	(o_wb_ack),
		.i_wb_data	(o_wb_data)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk;
	end

	//////////////////////////////////////////////////////////////////////
	// PHY model
	//////////////////////////////////////////////////////////////////////

	// Turnaround Z then 0, then the read word MSB first
	always @(posedge i_clk)
	begin
		mdc_q <= o_mdc;
		if (o_mdwe)
		begin
			i_mdio <= o_mdio;
			rd_bit <= 0;
		end else if (mdc_q && !o_mdc)
		begin
			if (rd_bit == 0)
				i_mdio <= 1'b1;
			else if (rd_bit == 1)
				i_mdio <= 1'b0;
			else if (rd_bit < 18)
				i_mdio <= cur_rd_data[17 - rd_bit];
			rd_bit <= rd_bit + 1;
		end
	end

	always @(posedge i_clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_limit)
		begin
			$display("Timeout: the run did not finish within %0d clock cycles",
				cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic wait_stall_low();
		do
			@(posedge i_clk);
		while (o_wb_stall);
	endtask

	// Op 0 write, 1 read, 2 write that drops cyc mid frame
	task automatic run_transfer(input logic [27:0] v);
		logic [3:0] op;
		op = v[27:24];
		cur_rd_data = v[15:0];
		wait_stall_low();
		i_wb_cyc  <= 1'b1;
		i_wb_stb  <= 1'b1;
		i_wb_we   <= (op != 4'h1);
		i_wb_addr <= v[20:16];
		i_wb_data <= v[15:0];
		@(posedge i_clk);
		i_wb_stb <= 1'b0;
		// Request is held inside the DUT, so the bus lines move on
		i_wb_addr <= ~v[20:16];
		i_wb_data <= ~v[15:0];
		if (op == 4'h2)
		begin
			repeat (8 * MDC_CLOCKS) @(posedge i_clk);
			i_wb_cyc <= 1'b0;
			wait_stall_low();
		end else
		begin
			do
				@(posedge i_clk);
			while (!o_wb_ack);
			i_wb_cyc <= 1'b0;
		end
	endtask

	initial
	begin
		i_reset   <= 1'b1;
		i_wb_cyc  <= 1'b0;
		i_wb_stb  <= 1'b0;
		i_wb_we   <= 1'b0;
		i_wb_addr <= '0;
		i_wb_data <= '0;
		i_mdio    <= 1'b1;
		for (int i = 0; i < 16; i++)
			vec_mem[i] = {4'hf, 24'(i)};
		$readmemh("verif/mdio_vectors.txt", vec_mem);
		nvec = 0;
		for (int i = 0; i < 16; i++)
			if (nvec == i && vec_mem[i][27:24] != 4'hf)
				nvec = i + 1;
		// Worst transfer is well under 40 MDC periods
		cycle_limit = (nvec * 40 + PREAMBLE_BITS + 8) * MDC_CLOCKS + 20;
		repeat (4) @(posedge i_clk);
		i_reset <= 1'b0;
		for (int i = 0; i < nvec; i++)
			run_transfer(vec_mem[i]);
		repeat (4) @(posedge i_clk);
		total_errors = chk0.error_count + chk0.count_missing() + dut0.props0.fail_count;
		$display("Summary: %0d errors, %0d assertion failures, %0d frames, %0d acks",
			total_errors, dut0.props0.fail_count, chk0.frame_count, chk0.ack_count);
		if (total_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/mdio_vectors.txt ====
// One transfer per line, seven hex digits: op, register (2 digits), data (4 digits)
// op 0 write, 1 read (data is what the PHY returns), 2 write abandoned by dropping cyc
0001140
101796d
00401e1
1020022
2090300
1031622
01fa5a5
11f5a5a

// ==== files.f ====
common/mdio_pkg.sv
mdio/mdc_clock_gen.sv
mdio/mdio_frame_engine.sv
hw/wb_mdio_slave.sv
hw/enet_mdio_ctrl.sv
verif/mdio_properties.sv
verif/mdio_checker.sv
verif/enet_mdio_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module enet_mdio_tb \
		-f files.f -Mdir obj_dir -o enet_mdio_sim
	@out="$$(./obj_dir/enet_mdio_sim +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
